// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rtlinf
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
rtl/rtlinf_pkg.sv
rtl/fetch_sequencer.sv
rtl/distribute_in.sv
rtl/mac_lane.sv
rtl/distribute_out.sv
rtl/write_clip.sv
rtl/rtlinf_kernel.sv
sim/tb_memory.sv
sim/tb_rtlinf.sv

// ==== rtl/distribute_in.sv ====
`default_nettype none

module distribute_in (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  rtlinf_pkg::kernel_cfg_t                         cfg,
  input  logic [rtlinf_pkg::num_inputs-1:0]               act_valid,
  input  rtlinf_pkg::group_t [rtlinf_pkg::num_inputs-1:0] act_data,
  input  logic                                            weight_valid,
  input  rtlinf_pkg::weight_word_t                        weight_data,
  output rtlinf_pkg::lane_in_t [rtlinf_pkg::num_lanes-1:0] lanes
);
  import rtlinf_pkg::*;

  weight_word_t weight_q;  // weights of the current iteration

  logic   [num_lanes-1:0] beat_valid;
  group_t [num_lanes-1:0] beat_act;

  always_ff @(posedge clk) begin
    if (weight_valid) begin
      weight_q <= weight_data;
    end
  end

  // routing by input mode
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      if (cfg.mode_in) begin
        beat_valid[l] = act_valid[l];
        beat_act[l]   = act_data[l];
      end else begin
        beat_valid[l] = act_valid[0]; // broadcast
        beat_act[l]   = act_data[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int l = 0; l < num_lanes; l++) begin
        lanes[l].valid <= 1'b0;
      end
    end else begin
      for (int l = 0; l < num_lanes; l++) begin
        lanes[l].valid <= beat_valid[l];
        if (beat_valid[l]) begin
          lanes[l].act    <= beat_act[l];
          lanes[l].weight <= weight_q[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/distribute_out.sv ====
`default_nettype none

module distribute_out (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  rtlinf_pkg::kernel_cfg_t                            cfg,
  input  rtlinf_pkg::lane_out_t [rtlinf_pkg::num_lanes-1:0]   lanes,
  output rtlinf_pkg::lane_out_t [rtlinf_pkg::num_outputs-1:0] outs
);
  import rtlinf_pkg::*;

  acc_group_t           total;       // element-wise sum over lanes, 16-bit wrap
  logic [num_lanes-1:0] lane_valid;

  always_comb begin
    total = '0;
    for (int l = 0; l < num_lanes; l++) begin
      lane_valid[l] = lanes[l].valid;
      for (int e = 0; e < group_size; e++) begin
        total[e] = total[e] + lanes[l].sum[e];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int p = 0; p < num_outputs; p++) begin
        outs[p].valid <= 1'b0;
      end
    end else if (cfg.mode_out) begin
      for (int p = 0; p < num_outputs; p++) begin
        outs[p] <= lanes[p];  // lane i to port i
      end
    end else begin
      outs[0].valid <= |lane_valid;
      outs[0].sum   <= total;
      for (int p = 1; p < num_outputs; p++) begin
        outs[p].valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_sequencer.sv ====
`default_nettype none

module fetch_sequencer (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           configure,
  input  rtlinf_pkg::kernel_cfg_t                        cfg,
  output logic [rtlinf_pkg::num_inputs-1:0]              act_read,
  output rtlinf_pkg::addr_t [rtlinf_pkg::num_inputs-1:0] act_addr,
  output logic                                           weight_read,
  output rtlinf_pkg::addr_t                              weight_addr
);
  import rtlinf_pkg::*;

  seq_state_t state;
  iter_t      iter;    // current iteration
  reads_t     rd;      // read position inside the iteration
  addr_t      offset;  // iteration * num_reads + rd, kept as a running count

  logic last_read;
  logic last_iter;

  assign last_read = (rd == cfg.num_reads - 1'b1);
  assign last_iter = (iter == cfg.num_iters - 1'b1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= idle;
      iter   <= '0;
      rd     <= '0;
      offset <= '0;
    end else if (configure) begin
      // a new configure restarts the run from scratch
      state  <= fetch_weight;
      iter   <= '0;
      rd     <= '0;
      offset <= '0;
    end else begin
      case (state)
        fetch_weight: begin
          state <= fetch_acts;
          rd    <= '0;
        end
        fetch_acts: begin
          offset <= offset + 1'b1;
          if (last_read) begin
            rd <= '0;
            if (last_iter) begin
              state <= idle;
            end else begin
              iter  <= iter + 1'b1;
              state <= fetch_weight; // next weight right behind the last read
            end
          end else begin
            rd <= rd + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign weight_read = (state == fetch_weight);
  assign weight_addr = cfg.read_addr + iter;

  always_comb begin
    act_read = '0;
    if (state == fetch_acts) begin
      act_read = cfg.mode_in ? '1 : {{(num_inputs-1){1'b0}}, 1'b1}; // broadcast reads input 0 only
    end
    for (int i = 0; i < num_inputs; i++) begin
      act_addr[i] = cfg.read_addr + offset;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mac_lane.sv ====
`default_nettype none

module mac_lane (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    configure,
  input  rtlinf_pkg::kernel_cfg_t cfg,
  input  rtlinf_pkg::lane_in_t    lane_in,
  output rtlinf_pkg::lane_out_t   lane_out
);
  import rtlinf_pkg::*;

  acc_group_t prod_q;
  logic       prod_valid;

  reads_t rd_idx;   // read position of the beat in stage 2
  iter_t  it_idx;   // its iteration

  acc_group_t acc_mem [acc_depth];
  acc_group_t acc_next;

  logic first_iter;
  logic last_iter;
  logic last_read;

  // stage 1: group times lane weight
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= lane_in.valid;
      if (lane_in.valid) begin
        for (int e = 0; e < group_size; e++) begin
          prod_q[e] <= $signed(lane_in.act[e]) * $signed(lane_in.weight);
        end
      end
    end
  end

  assign first_iter = (it_idx == '0);
  assign last_iter  = (it_idx == cfg.num_iters - 1'b1);
  assign last_read  = (rd_idx == cfg.num_reads - 1'b1);

  // first iteration overwrites whatever an earlier run left behind
  always_comb begin
    for (int e = 0; e < group_size; e++) begin
      acc_next[e] = first_iter ? prod_q[e] : acc_mem[rd_idx][e] + prod_q[e];
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid) begin
      acc_mem[rd_idx] <= acc_next;
    end
  end

  // stage 2: accumulate and index bookkeeping
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_idx         <= '0;
      it_idx         <= '0;
      lane_out.valid <= 1'b0;
    end else begin
      lane_out.valid <= prod_valid && last_iter; // only final sums leave the lane
      if (prod_valid) begin
        lane_out.sum <= acc_next;
      end
      if (configure) begin
        rd_idx <= '0;
        it_idx <= '0;
      end else if (prod_valid) begin
        if (last_read) begin
          rd_idx <= '0;
          it_idx <= it_idx + 1'b1;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rtlinf_kernel.sv ====
`default_nettype none

module rtlinf_kernel (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             configure,
  input  rtlinf_pkg::kernel_cfg_t                          cfg_in,
  output logic [rtlinf_pkg::num_inputs-1:0]                act_read,
  output rtlinf_pkg::addr_t [rtlinf_pkg::num_inputs-1:0]   act_addr,
  input  logic [rtlinf_pkg::num_inputs-1:0]                act_valid,
  input  rtlinf_pkg::group_t [rtlinf_pkg::num_inputs-1:0]  act_data,
  output logic                                             weight_read,
  output rtlinf_pkg::addr_t                                weight_addr,
  input  logic                                             weight_valid,
  input  rtlinf_pkg::weight_word_t                         weight_data,
  output wire [rtlinf_pkg::num_outputs-1:0]                valid_out,
  output wire rtlinf_pkg::addr_t [rtlinf_pkg::num_outputs-1:0]  addr_out,
  output wire rtlinf_pkg::group_t [rtlinf_pkg::num_outputs-1:0] data_out
);
  import rtlinf_pkg::*;

  kernel_cfg_t                     cfg;        // held for the whole run
  lane_in_t  [num_lanes-1:0]       lanes_in;
  wire lane_out_t [num_lanes-1:0]  lanes_out;
  lane_out_t [num_outputs-1:0]     outs;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (configure) begin
      cfg <= cfg_in;
    end
  end

  fetch_sequencer i_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .configure   (configure),
    .cfg         (cfg),
    .act_read    (act_read),
    .act_addr    (act_addr),
    .weight_read (weight_read),
    .weight_addr (weight_addr)
  );

  distribute_in i_din (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .act_valid    (act_valid),
    .act_data     (act_data),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .lanes        (lanes_in)
  );

  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    mac_lane i_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .configure (configure),
      .cfg       (cfg),
      .lane_in   (lanes_in[l]),
      .lane_out  (lanes_out[l])
    );
  end

  distribute_out i_dout (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg),
    .lanes (lanes_out),
    .outs  (outs)
  );

  for (genvar p = 0; p < num_outputs; p++) begin : g_port
    write_clip i_wr (
      .clk       (clk),
      .rst_n     (rst_n),
      .configure (configure),
      .cfg       (cfg),
      .in_beat   (outs[p]),
      .valid_out (valid_out[p]),
      .addr_out  (addr_out[p]),
      .data_out  (data_out[p])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/rtlinf_pkg.sv ====
`default_nettype none

package rtlinf_pkg;

  localparam int group_size  = 4;   // elements per activation group
  localparam int data_width  = 8;
  localparam int num_inputs  = 4;
  localparam int num_lanes   = 4;
  localparam int num_outputs = 4;
  localparam int addr_width  = 8;
  localparam int iter_width  = 8;
  localparam int reads_width = 6;

  localparam int prod_width  = 2 * data_width;
  localparam int acc_depth   = 2 ** reads_width; // one entry per read position

  typedef logic signed [data_width-1:0] data_t;
  typedef logic signed [prod_width-1:0] prod_t;  // wraps modulo 2^16
  typedef data_t [group_size-1:0]       group_t;
  typedef prod_t [group_size-1:0]       acc_group_t;
  typedef data_t [num_lanes-1:0]        weight_word_t; // byte l feeds lane l
  typedef logic [addr_width-1:0]        addr_t;
  typedef logic [iter_width-1:0]        iter_t;
  typedef logic [reads_width-1:0]       reads_t;

  // run configuration, captured on configure
  typedef struct packed {
    iter_t  num_iters;
    reads_t num_reads;
    addr_t  read_addr;
    addr_t  write_addr;
    data_t  min_clip;
    data_t  max_clip;
    logic   mode_in;   // 0 broadcast input 0, 1 input i to lane i
    logic   mode_out;  // 0 sum of lanes on port 0, 1 lane i to port i
  } kernel_cfg_t;

  typedef struct packed {
    logic   valid;
    group_t act;
    data_t  weight;
  } lane_in_t;

  typedef struct packed {
    logic       valid;
    acc_group_t sum;
  } lane_out_t;

  typedef enum logic [1:0] {
    idle,
    fetch_weight,
    fetch_acts
  } seq_state_t;

endpackage

`default_nettype wire

// ==== rtl/write_clip.sv ====
`default_nettype none

module write_clip (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    configure,
  input  rtlinf_pkg::kernel_cfg_t cfg,
  input  rtlinf_pkg::lane_out_t   in_beat,
  output logic                    valid_out,
  output rtlinf_pkg::addr_t       addr_out,
  output rtlinf_pkg::group_t      data_out
);
  import rtlinf_pkg::*;

  addr_t  beat_cnt;   // beats written since configure
  group_t clipped;
  prod_t  lo;
  prod_t  hi;

  assign lo = prod_t'(cfg.min_clip);  // sign extended limits
  assign hi = prod_t'(cfg.max_clip);

  always_comb begin
    for (int e = 0; e < group_size; e++) begin
      if (in_beat.sum[e] < lo) begin
        clipped[e] = cfg.min_clip;
      end else if (in_beat.sum[e] > hi) begin
        clipped[e] = cfg.max_clip;
      end else begin
        clipped[e] = in_beat.sum[e][data_width-1:0]; // in range, low byte is exact
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      valid_out <= in_beat.valid;
      if (in_beat.valid) begin
        addr_out <= cfg.write_addr + beat_cnt;
        data_out <= clipped;
      end
      if (configure) begin
        beat_cnt <= '0;
      end else if (in_beat.valid) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_memory.sv ====
`default_nettype none

module tb_memory (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [rtlinf_pkg::num_inputs-1:0]                act_read,
  input  rtlinf_pkg::addr_t [rtlinf_pkg::num_inputs-1:0]   act_addr,
  output logic [rtlinf_pkg::num_inputs-1:0]                act_valid,
  output rtlinf_pkg::group_t [rtlinf_pkg::num_inputs-1:0]  act_data,
  input  logic                                             weight_read,
  input  rtlinf_pkg::addr_t                                weight_addr,
  output logic                                             weight_valid,
  output rtlinf_pkg::weight_word_t                         weight_data,
  input  logic [rtlinf_pkg::num_outputs-1:0]               valid_out,
  input  rtlinf_pkg::addr_t [rtlinf_pkg::num_outputs-1:0]  addr_out,
  input  rtlinf_pkg::group_t [rtlinf_pkg::num_outputs-1:0] data_out
);
  import rtlinf_pkg::*;

  localparam int mem_words = 2 ** addr_width;

  group_t       act_mem    [num_inputs][mem_words];
  weight_word_t weight_mem [mem_words];
  group_t       out_mem    [num_outputs][mem_words];  // one result memory per write port

  initial begin
    act_valid    = '0;
    act_data     = '0;
    weight_valid = 1'b0;
    weight_data  = '0;
    void'($urandom(32'he678));  // single seed for the whole run
    for (int i = 0; i < num_inputs; i++) begin
      for (int a = 0; a < mem_words; a++) begin
        act_mem[i][a] = $urandom;
      end
    end
    for (int a = 0; a < mem_words; a++) begin
      weight_mem[a] = $urandom;
    end
  end

  // one cycle read latency, answers in request order
  always @(posedge clk) begin
    if (!rst_n) begin
      act_valid    <= '0;
      weight_valid <= 1'b0;
    end else begin
      act_valid    <= act_read;
      weight_valid <= weight_read;
      for (int i = 0; i < num_inputs; i++) begin
        if (act_read[i]) begin
          act_data[i] <= act_mem[i][act_addr[i]];
        end
      end
      if (weight_read) begin
        weight_data <= weight_mem[weight_addr];
      end
      for (int p = 0; p < num_outputs; p++) begin
        if (valid_out[p]) begin
          out_mem[p][addr_out[p]] <= data_out[p];  // writes always accepted
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_rtlinf.sv ====
`default_nettype none

module tb_rtlinf;
  import rtlinf_pkg::*;

  localparam int num_tests   = 6;
  localparam int idle_cycles = 20;  // quiet window before the first configure
  localparam int addr_span   = 2 ** addr_width;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        configure;
  kernel_cfg_t cfg_in;

  logic         [num_inputs-1:0]  act_read;
  addr_t        [num_inputs-1:0]  act_addr;
  logic         [num_inputs-1:0]  act_valid;
  group_t       [num_inputs-1:0]  act_data;
  logic                           weight_read;
  addr_t                          weight_addr;
  logic                           weight_valid;
  weight_word_t                   weight_data;
  logic         [num_outputs-1:0] valid_out;
  addr_t        [num_outputs-1:0] addr_out;
  group_t       [num_outputs-1:0] data_out;

  kernel_cfg_t exp_cfg = '0;      // configuration the DUT is running
  logic        configured = 1'b0;
  int          write_cnt [num_outputs];
  int          writes_total = 0;
  int          errors = 0;

  always #4 clk = ~clk;

  rtlinf_kernel i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .configure    (configure),
    .cfg_in       (cfg_in),
    .act_read     (act_read),
    .act_addr     (act_addr),
    .act_valid    (act_valid),
    .act_data     (act_data),
    .weight_read  (weight_read),
    .weight_addr  (weight_addr),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .valid_out    (valid_out),
    .addr_out     (addr_out),
    .data_out     (data_out)
  );

  tb_memory i_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .act_read     (act_read),
    .act_addr     (act_addr),
    .act_valid    (act_valid),
    .act_data     (act_data),
    .weight_read  (weight_read),
    .weight_addr  (weight_addr),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .valid_out    (valid_out),
    .addr_out     (addr_out),
    .data_out     (data_out)
  );

  task automatic stop_on_error(input string what);
    errors++;
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic int byte_of(input logic [31:0] word, input int idx);
    return int'($signed(word[8*idx +: 8]));
  endfunction

  function automatic kernel_cfg_t make_cfg(input int iters, input int reads, input int raddr,
                                           input int waddr, input int lo, input int hi,
                                           input bit m_in, input bit m_out);
    kernel_cfg_t c;
    c.num_iters  = iter_t'(iters);
    c.num_reads  = reads_t'(reads);
    c.read_addr  = addr_t'(raddr);
    c.write_addr = addr_t'(waddr);
    c.min_clip   = data_t'(lo);
    c.max_clip   = data_t'(hi);
    c.mode_in    = m_in;
    c.mode_out   = m_out;
    return c;
  endfunction

  // iters, reads, read addr, write addr, clip range, mode_in, mode_out
  function automatic kernel_cfg_t test_cfg(input int idx);
    case (idx)
      0:       return make_cfg(3, 8, 'h00, 'h10, -128, 127, 1'b1, 1'b1);
      1:       return make_cfg(2, 5, 'h20, 'h40, -5, 7, 1'b0, 1'b1);      // broadcast, narrow clip
      2:       return make_cfg(4, 6, 'h30, 'h80, -128, 127, 1'b1, 1'b0);  // lanes summed
      3:       return make_cfg(2, 7, 'h60, 'h20, -20, 30, 1'b0, 1'b0);
      4:       return make_cfg(3, 8, 'h00, 'h10, -5, 7, 1'b1, 1'b1);      // restarts at 'h10
      default: return make_cfg(5, 40, 'h10, 'hf0, -128, 127, 1'b1, 1'b1); // write address wraps
    endcase
  endfunction

  // weighted sums per lane over all iterations, then output mode and clip
  function automatic logic [31:0] expected_word(input int p, input int r);
    int          total [group_size];
    int          src;
    int          a_addr;
    int          w_addr;
    int          lo;
    int          hi;
    int          val;
    logic [15:0] wrapped;
    logic [31:0] word;
    lo = int'($signed(exp_cfg.min_clip));
    hi = int'($signed(exp_cfg.max_clip));
    for (int e = 0; e < group_size; e++) begin
      total[e] = 0;
    end
    for (int l = 0; l < num_lanes; l++) begin
      if (!exp_cfg.mode_out || l == p) begin
        src = exp_cfg.mode_in ? l : 0;
        for (int it = 0; it < int'(exp_cfg.num_iters); it++) begin
          w_addr = (int'(exp_cfg.read_addr) + it) % addr_span;
          a_addr = (int'(exp_cfg.read_addr) + it * int'(exp_cfg.num_reads) + r) % addr_span;
          for (int e = 0; e < group_size; e++) begin
            total[e] += byte_of(i_mem.act_mem[src][a_addr], e)
                        * byte_of(i_mem.weight_mem[w_addr], l);
          end
        end
      end
    end
    for (int e = 0; e < group_size; e++) begin
      wrapped = total[e][15:0];  // 16-bit accumulation wrap
      val     = int'($signed(wrapped));
      if (val < lo) begin
        val = lo;
      end else if (val > hi) begin
        val = hi;
      end
      word[8*e +: 8] = val[7:0];
    end
    return word;
  endfunction

  function automatic bit within_limits(input logic [31:0] word);
    for (int e = 0; e < group_size; e++) begin
      if (byte_of(word, e) < int'($signed(exp_cfg.min_clip)) ||
          byte_of(word, e) > int'($signed(exp_cfg.max_clip))) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // results left in the output memories once a run has drained
  task automatic check_stored(input kernel_cfg_t c);
    logic [31:0] want;
    addr_t       a;
    for (int p = 0; p < num_outputs; p++) begin
      if (c.mode_out || p == 0) begin
        for (int r = 0; r < int'(c.num_reads); r++) begin
          a    = addr_t'(int'(c.write_addr) + r);
          want = expected_word(p, r);
          assert (i_mem.out_mem[p][a] == want)
            else stop_on_error($sformatf("MISMATCH t=%0t out_mem[%0d][%02h] expected=%08h got=%08h",
                                         $time, p, a, want, i_mem.out_mem[p][a]));
        end
      end
    end
  endtask

  // samples everything at the clock edge, before the DUT updates
  always @(posedge clk) begin
    int          n;
    logic [31:0] want;
    logic [7:0]  want_addr;
    n = 0;
    if (!rst_n) begin
      configured   <= 1'b0;
      writes_total <= 0;
      for (int p = 0; p < num_outputs; p++) begin
        write_cnt[p] <= 0;
      end
    end else if (configure) begin
      exp_cfg      <= cfg_in;  // same edge that loads the DUT config
      configured   <= 1'b1;
      writes_total <= 0;
      for (int p = 0; p < num_outputs; p++) begin
        write_cnt[p] <= 0;
      end
    end else begin
      if (!configured) begin
        assert (act_read == '0 && !weight_read && valid_out == '0)
          else stop_on_error("read or write activity before the first configure");
      end
      assert (exp_cfg.mode_in || act_read[num_inputs-1:1] == '0)
        else stop_on_error("act_read above bit 0 raised in broadcast mode");
      assert (exp_cfg.mode_out || valid_out[num_outputs-1:1] == '0)
        else stop_on_error("valid_out above port 0 raised in summing mode");
      for (int p = 0; p < num_outputs; p++) begin
        if (valid_out[p]) begin
          want      = expected_word(p, write_cnt[p]);
          want_addr = 8'(int'(exp_cfg.write_addr) + write_cnt[p]);
          assert (write_cnt[p] < int'(exp_cfg.num_reads))
            else stop_on_error($sformatf("port %0d wrote more than num_reads groups", p));
          assert (addr_out[p] == want_addr)
            else stop_on_error($sformatf("MISMATCH t=%0t addr_out[%0d] expected=%02h got=%02h",
                                         $time, p, want_addr, addr_out[p]));
          assert (within_limits(data_out[p]))
            else stop_on_error($sformatf("port %0d wrote %08h outside the clip range",
                                         p, data_out[p]));
          assert (data_out[p] == want)
            else stop_on_error($sformatf("MISMATCH t=%0t data_out[%0d] expected=%08h got=%08h",
                                         $time, p, want, data_out[p]));
          write_cnt[p] <= write_cnt[p] + 1;
          n++;
        end
      end
      writes_total <= writes_total + n;
    end
  end

  task automatic run_test(input int idx);
    kernel_cfg_t c;
    int          expected;
    c        = test_cfg(idx);
    expected = c.mode_out ? int'(c.num_reads) * num_outputs : int'(c.num_reads);
    configure <= 1'b1;
    cfg_in    <= c;
    @(posedge clk);
    configure <= 1'b0;
    @(posedge clk);
    while (writes_total < expected) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);  // any stray write shows up here
    check_stored(c);
    $display("test %0d done, %0d writes", idx, writes_total);
  endtask

  initial begin : watchdog
    int          budget;
    kernel_cfg_t c;
    budget = 8 + idle_cycles + 20;
    for (int t = 0; t < num_tests; t++) begin
      c = test_cfg(t);
      budget += int'(c.num_iters) * (int'(c.num_reads) + 1) + 30;
    end
    repeat (budget) @(posedge clk);
    stop_on_error($sformatf("timeout, run not finished after %0d cycles", budget));
  end

  initial begin
    rst_n     <= 1'b0;
    configure <= 1'b0;
    cfg_in    <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (idle_cycles) @(posedge clk);
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
